// ==== design/commit_pkg.sv ====
// ################################################
// Shared sizes, enums and structs of the commit stage
// Head entries carry 64-bit pc and value fields
// regardless of the XLEN chosen at the top level
// Opcodes follow the RV64 major opcode map
// ################################################

package commit_pkg;

    // Instruction and index widths
    localparam int ILEN         = 32;
    localparam int REG_IDX_LEN  = 5;
    localparam int ROB_IDX_LEN  = 4;
    localparam int EXCEPT_LEN   = 4;

    // Default data width and fixed width of struct payloads
    localparam int XLEN_DEFAULT = 64;

    // Major opcode field in bits [6:0] of the instruction
    typedef enum logic [6:0] {
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        OP        = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_32     = 7'b0111011,
        OP_IMM_32 = 7'b0011011,
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        BRANCH    = 7'b1100011,
        LOAD_FP   = 7'b0000111,
        STORE_FP  = 7'b0100111,
        OP_FP     = 7'b1010011,
        MISC_MEM  = 7'b0001111,
        SYSTEM    = 7'b1110011
    } opcode_e;

    // Action taken when the head entry retires
    typedef enum logic [2:0] {
        CC_INT_WB,
        CC_FP_WB,
        CC_STORE,
        CC_NONE,
        CC_ILLEGAL
    } commit_class_e;

    // Exception handler states
    typedef enum logic {
        EH_IDLE,
        EH_TRAP
    } eh_state_e;

    // Entry at the head of the ROB
    typedef struct packed {
        logic [ILEN-1:0]         instruction;
        logic [XLEN_DEFAULT-1:0] pc;
        logic [REG_IDX_LEN-1:0]  rd_idx;
        logic [XLEN_DEFAULT-1:0] value;
        logic                    except_raised;
        logic [EXCEPT_LEN-1:0]   except_code;
    } rob_head_t;

    // Register file write request
    typedef struct packed {
        logic                    valid;
        logic [REG_IDX_LEN-1:0]  rd_idx;
        logic [XLEN_DEFAULT-1:0] data;
    } rf_wr_t;

    // Trap report towards the rest of the core
    typedef struct packed {
        logic                    valid;
        logic [EXCEPT_LEN-1:0]   cause;
        logic [XLEN_DEFAULT-1:0] pc;
        logic [ROB_IDX_LEN-1:0]  rob_idx;
    } trap_t;

endpackage

// ==== design/commit_decoder.sv ====
// ################################################
// Commit decoder for the ROB head instruction
// Pure combinational, classification by opcode only
// Unknown opcodes come out as CC_ILLEGAL
// Only stores can be held back, by the store buffer
// ################################################

`timescale 1ns/10ps

module commit_decoder (
    // Instruction at the head of the ROB
    input  logic [commit_pkg::ILEN-1:0] instruction_i,
    // Store buffer is retiring the matching store
    input  logic                        sb_store_committing_i,
    // Commit action and readiness
    output commit_pkg::commit_class_e   class_o,
    output logic                        comm_possible_o
);

    // Major opcode seen through the enum
    commit_pkg::opcode_e opcode;

    assign opcode = commit_pkg::opcode_e'(instruction_i[6:0]);

    // Opcode to commit class
    always_comb begin
        case (opcode)
            // Integer results, rd = x0 still counts as a write
            commit_pkg::LOAD,
            commit_pkg::OP,
            commit_pkg::OP_IMM,
            commit_pkg::OP_32,
            commit_pkg::OP_IMM_32,
            commit_pkg::LUI,
            commit_pkg::AUIPC,
            commit_pkg::JAL,
            commit_pkg::JALR: begin
                class_o = commit_pkg::CC_INT_WB;
            end
            // Floating-point results
            // FP compares and moves to x regs are not split out
            commit_pkg::LOAD_FP,
            commit_pkg::OP_FP: begin
                class_o = commit_pkg::CC_FP_WB;
            end
            // Stores of either kind
            commit_pkg::STORE,
            commit_pkg::STORE_FP: begin
                class_o = commit_pkg::CC_STORE;
            end
            // Nothing to write back
            commit_pkg::BRANCH,
            commit_pkg::MISC_MEM,
            commit_pkg::SYSTEM: begin
                class_o = commit_pkg::CC_NONE;
            end
            default: begin
                class_o = commit_pkg::CC_ILLEGAL;
            end
        endcase
    end

    // A store waits for the store buffer
    // All other classes retire right away
    assign comm_possible_o = (class_o != commit_pkg::CC_STORE) | sb_store_committing_i;

endmodule

// ==== design/except_handler.sv ====
// ################################################
// Exception handler of the commit stage
// Takes one excepting head entry at a time
// Trap report and flush last exactly one cycle
// No new entry may be taken while a trap is out
// ################################################

`timescale 1ns/10ps

module except_handler (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    // Excepting entry popped this cycle
    input  logic                               take_i,
    input  commit_pkg::rob_head_t              head_i,
    input  logic [commit_pkg::ROB_IDX_LEN-1:0] head_idx_i,
    // Handler status and trap outputs
    output logic                               busy_o,
    output commit_pkg::trap_t                  trap_o,
    output logic                               flush_o
);

    commit_pkg::eh_state_e state_q;
    commit_pkg::eh_state_e state_d;

    // Captured trap information
    logic [commit_pkg::EXCEPT_LEN-1:0]   cause_q;
    logic [commit_pkg::XLEN_DEFAULT-1:0] pc_q;
    logic [commit_pkg::ROB_IDX_LEN-1:0]  idx_q;

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            commit_pkg::EH_IDLE: begin
                if (take_i) begin
                    state_d = commit_pkg::EH_TRAP;
                end
            end
            // Single cycle in trap, then back to idle
            commit_pkg::EH_TRAP: begin
                state_d = commit_pkg::EH_IDLE;
            end
            default: begin
                state_d = commit_pkg::EH_IDLE;
            end
        endcase
    end

    // State and trap capture
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= commit_pkg::EH_IDLE;
            cause_q <= '0;
            pc_q    <= '0;
            idx_q   <= '0;
        end else begin
            state_q <= state_d;
            if (take_i) begin
                cause_q <= head_i.except_code;
                pc_q    <= head_i.pc;
                idx_q   <= head_idx_i;
            end
        end
    end

    // Outputs follow the state directly
    assign busy_o        = (state_q == commit_pkg::EH_TRAP);
    assign flush_o       = busy_o;
    assign trap_o.valid  = busy_o;
    assign trap_o.cause  = cause_q;
    assign trap_o.pc     = pc_q;
    assign trap_o.rob_idx = idx_q;

    // Commit logic must stall the ROB while a trap is reported
    a_no_take_in_trap: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (state_q == commit_pkg::EH_TRAP) |-> !take_i)
        else $error("exception taken while a trap is still being reported");

endmodule

// ==== design/commit_logic.sv ====
// ################################################
// Commit logic for the ROB head entry
// Pop means valid and ready high in the same cycle
// Register files always accept a write
// One rd index and value feed both register files
// Data above XLEN is cleared before the write
// ################################################

`timescale 1ns/10ps

module commit_logic #(
    parameter int XLEN = commit_pkg::XLEN_DEFAULT
) (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    // ROB handshake and head entry
    input  logic                               rob_valid_i,
    input  commit_pkg::rob_head_t              rob_head_i,
    input  logic [commit_pkg::ROB_IDX_LEN-1:0] rob_head_idx_i,
    output logic                               rob_ready_o,
    // Store buffer condition
    input  logic                               sb_store_committing_i,
    // Register file write requests
    output commit_pkg::rf_wr_t                 int_wr_o,
    output commit_pkg::rf_wr_t                 fp_wr_o,
    // Trap report and pipeline flush
    output commit_pkg::trap_t                  trap_o,
    output logic                               rob_flush_o
);

    // Keeps only the low XLEN bits of a value
    localparam logic [commit_pkg::XLEN_DEFAULT-1:0] DATA_MASK =
        {commit_pkg::XLEN_DEFAULT{1'b1}} >> (commit_pkg::XLEN_DEFAULT - XLEN);

    commit_pkg::commit_class_e cd_class;
    logic                      cd_comm_possible;
    logic                      eh_busy;
    logic                      eh_take;
    logic                      pop;
    logic                      wb_en;
    commit_pkg::rf_wr_t        int_wr;
    commit_pkg::rf_wr_t        fp_wr;

    commit_decoder u_commit_decoder (
        .instruction_i         (rob_head_i.instruction),
        .sb_store_committing_i (sb_store_committing_i),
        .class_o               (cd_class),
        .comm_possible_o       (cd_comm_possible)
    );

    except_handler u_except_handler (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .take_i     (eh_take),
        .head_i     (rob_head_i),
        .head_idx_i (rob_head_idx_i),
        .busy_o     (eh_busy),
        .trap_o     (trap_o),
        .flush_o    (rob_flush_o)
    );

    // Excepting entries skip the store buffer wait
    assign rob_ready_o = rob_valid_i & ~eh_busy
                       & (rob_head_i.except_raised | cd_comm_possible);
    assign pop         = rob_valid_i & rob_ready_o;

    // Popped entry either writes back or traps
    assign wb_en   = pop & ~rob_head_i.except_raised;
    assign eh_take = pop & rob_head_i.except_raised;

    // Same index and data towards both files
    // Illegal entries get no valid and retire like CC_NONE
    assign int_wr.valid  = wb_en & (cd_class == commit_pkg::CC_INT_WB);
    assign int_wr.rd_idx = rob_head_i.rd_idx;
    assign int_wr.data   = rob_head_i.value & DATA_MASK;
    assign fp_wr.valid   = wb_en & (cd_class == commit_pkg::CC_FP_WB);
    assign fp_wr.rd_idx  = rob_head_i.rd_idx;
    assign fp_wr.data    = rob_head_i.value & DATA_MASK;

    assign int_wr_o = int_wr;
    assign fp_wr_o  = fp_wr;

    // Decoder classes are exclusive, so at most one file is written
    a_one_file_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(int_wr.valid && fp_wr.valid))
        else $error("integer and FP register files written in the same cycle");

    // ROB stays stalled for the whole trap report
    a_no_pop_in_trap: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        eh_busy |-> !rob_ready_o)
        else $error("ROB popped while a trap is being reported");

    // An unknown opcode must come with an exception from upstream
    a_no_illegal_retire: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_en |-> (cd_class != commit_pkg::CC_ILLEGAL))
        else $error("illegal instruction retired without an exception");

endmodule

// ==== design/reg_file.sv ====
// ################################################
// Register file with one write and one read port
// 32 entries of XLEN bits, cleared on reset
// XLEN may not exceed the 64-bit request width
// ZERO_REG makes entry 0 a hardwired zero
// Read data is combinational
// ################################################

`timescale 1ns/10ps

module reg_file #(
    parameter int XLEN     = commit_pkg::XLEN_DEFAULT,
    parameter bit ZERO_REG = 1'b0
) (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    // Write request from the commit logic
    input  commit_pkg::rf_wr_t                 wr_i,
    // Read port
    input  logic [commit_pkg::REG_IDX_LEN-1:0] rs_idx_i,
    output logic [XLEN-1:0]                    rs_data_o
);

    localparam int NREGS = 2 ** commit_pkg::REG_IDX_LEN;

    logic [XLEN-1:0] regs_q [NREGS];
    logic            wr_zero;

    // Write aimed at the hardwired zero
    assign wr_zero = ZERO_REG && (wr_i.rd_idx == '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.valid && !wr_zero) begin
            regs_q[wr_i.rd_idx] <= wr_i.data[XLEN-1:0];
        end
    end

    // Entry 0 reads zero when hardwired
    always_comb begin
        if (ZERO_REG && (rs_idx_i == '0)) begin
            rs_data_o = '0;
        end else begin
            rs_data_o = regs_q[rs_idx_i];
        end
    end

    // Width check at elaboration
    if (XLEN < 1 || XLEN > commit_pkg::XLEN_DEFAULT) begin : g_bad_xlen
        $error("reg_file XLEN out of range");
    end

endmodule

// ==== design/commit_stage.sv ====
// ################################################
// Commit stage top level
// Connects the commit logic to the integer and
// FP register files
// XLEN sizes the register files, up to 64 bits
// Read ports show a write from the next cycle on
// ################################################

`timescale 1ns/10ps

module commit_stage #(
    parameter int XLEN = commit_pkg::XLEN_DEFAULT
) (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    // ROB interface
    input  logic                               rob_valid_i,
    input  commit_pkg::rob_head_t              rob_head_i,
    input  logic [commit_pkg::ROB_IDX_LEN-1:0] rob_head_idx_i,
    output logic                               rob_ready_o,
    // Store buffer condition
    input  logic                               sb_store_committing_i,
    // Trap report and flush
    output commit_pkg::trap_t                  trap_o,
    output logic                               rob_flush_o,
    // Register file read ports
    input  logic [commit_pkg::REG_IDX_LEN-1:0] int_rs_idx_i,
    output logic [XLEN-1:0]                    int_rs_data_o,
    input  logic [commit_pkg::REG_IDX_LEN-1:0] fp_rs_idx_i,
    output logic [XLEN-1:0]                    fp_rs_data_o
);

    commit_pkg::rf_wr_t int_wr;
    commit_pkg::rf_wr_t fp_wr;

    commit_logic #(.XLEN(XLEN)) u_commit_logic (
        .clk_i                 (clk_i),
        .arst_n_i              (arst_n_i),
        .rob_valid_i           (rob_valid_i),
        .rob_head_i            (rob_head_i),
        .rob_head_idx_i        (rob_head_idx_i),
        .rob_ready_o           (rob_ready_o),
        .sb_store_committing_i (sb_store_committing_i),
        .int_wr_o              (int_wr),
        .fp_wr_o               (fp_wr),
        .trap_o                (trap_o),
        .rob_flush_o           (rob_flush_o)
    );

    // Integer file with x0 hardwired to zero
    reg_file #(.XLEN(XLEN), .ZERO_REG(1'b1)) u_int_rf (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .wr_i      (int_wr),
        .rs_idx_i  (int_rs_idx_i),
        .rs_data_o (int_rs_data_o)
    );

    // FP file where f0 is an ordinary register
    reg_file #(.XLEN(XLEN), .ZERO_REG(1'b0)) u_fp_rf (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .wr_i      (fp_wr),
        .rs_idx_i  (fp_rs_idx_i),
        .rs_data_o (fp_rs_data_o)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
// ################################################
// Clock and reset source for the testbench
// Reset is released on a falling edge after
// RESET_CYCLES rising edges
// ################################################

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Active-low reset held for the first cycles
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

// ==== verif/commit_stage_tb.sv ====
// ################################################
// Testbench of the commit stage, XLEN 64
// Random head entries from a fixed-seed LCG
// Shadow register files follow every observed pop
// Concurrent assertions compare ready, trap and
// both read ports against the shadow model
// Illegal opcodes are only sent with an exception
// ################################################

`timescale 1ns/10ps

module commit_stage_tb;

    localparam int NUM_ENTRIES = 400;
    // At most 4 cycles per entry, plus reset and the read sweep
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 5;

    // Expected commit action of the entry on the bus
    typedef struct packed {
        logic int_wb;
        logic fp_wb;
        logic store;
    } exp_kind_t;

    logic                               clk;
    logic                               arst_n;
    logic                               rob_valid;
    commit_pkg::rob_head_t              rob_head;
    logic [commit_pkg::ROB_IDX_LEN-1:0] rob_head_idx;
    logic                               rob_ready;
    logic                               sb;
    commit_pkg::trap_t                  trap;
    logic                               rob_flush;
    logic [4:0]                         int_rs_idx;
    logic [4:0]                         fp_rs_idx;
    logic [63:0]                        int_rs_data;
    logic [63:0]                        fp_rs_data;

    // Shadow model and expectations
    logic [63:0]       int_model [32];
    logic [63:0]       fp_model [32];
    logic [63:0]       int_exp;
    logic [63:0]       fp_exp;
    commit_pkg::trap_t trap_exp;
    exp_kind_t         kind;
    logic              ready_exp;
    int                pop_count;
    int                cycle_count;
    logic [31:0]       rng_state;

    int ready_errs;
    int trap_errs;
    int int_errs;
    int fp_errs;

    // Opcodes grouped by commit class: 9 integer, 2 FP, 2 stores, 3 without write
    commit_pkg::opcode_e op_table [16] = '{
        commit_pkg::LOAD, commit_pkg::OP, commit_pkg::OP_IMM, commit_pkg::OP_32,
        commit_pkg::OP_IMM_32, commit_pkg::LUI, commit_pkg::AUIPC, commit_pkg::JAL,
        commit_pkg::JALR, commit_pkg::LOAD_FP, commit_pkg::OP_FP, commit_pkg::STORE,
        commit_pkg::STORE_FP, commit_pkg::BRANCH, commit_pkg::MISC_MEM, commit_pkg::SYSTEM
    };

    tb_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(5)) u_clock_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    commit_stage dut_i (
        .clk_i                 (clk),
        .arst_n_i              (arst_n),
        .rob_valid_i           (rob_valid),
        .rob_head_i            (rob_head),
        .rob_head_idx_i        (rob_head_idx),
        .rob_ready_o           (rob_ready),
        .sb_store_committing_i (sb),
        .trap_o                (trap),
        .rob_flush_o           (rob_flush),
        .int_rs_idx_i          (int_rs_idx),
        .int_rs_data_o         (int_rs_data),
        .fp_rs_idx_i           (fp_rs_idx),
        .fp_rs_data_o          (fp_rs_data)
    );

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Commit action of a table slot
    function automatic exp_kind_t kind_of(input int sel);
        exp_kind_t k;
        k.int_wb = (sel <= 8);
        k.fp_wb  = (sel == 9) || (sel == 10);
        k.store  = (sel == 11) || (sel == 12);
        return k;
    endfunction

    task automatic report_counts();
        $display("errors: ready %0d, trap %0d, int file %0d, fp file %0d",
                 ready_errs, trap_errs, int_errs, fp_errs);
    endtask

    // Ready rule: valid, no trap out, and an exception or no store wait
    assign ready_exp = rob_valid && !trap_exp.valid
                     && (rob_head.except_raised || !kind.store || sb);
    assign int_exp   = int_model[int_rs_idx];
    assign fp_exp    = fp_model[fp_rs_idx];

    // Shadow register files and trap expectation
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                int_model[i] <= '0;
                fp_model[i]  <= '0;
            end
            trap_exp  <= '0;
            pop_count <= 0;
        end else begin
            trap_exp.valid <= 1'b0;
            if (rob_valid && rob_ready) begin
                pop_count <= pop_count + 1;
                if (rob_head.except_raised) begin
                    trap_exp <= {1'b1, rob_head.except_code, rob_head.pc, rob_head_idx};
                end else if (kind.int_wb && rob_head.rd_idx != '0) begin
                    int_model[rob_head.rd_idx] <= rob_head.value;
                end else if (kind.fp_wb) begin
                    fp_model[rob_head.rd_idx] <= rob_head.value;
                end
            end
        end
    end

    a_ready: assert property (@(posedge clk) disable iff (!arst_n) rob_ready == ready_exp)
        else begin
            ready_errs++;
            $display("FAIL rob_ready: expected %b actual %b", $sampled(ready_exp),
                     $sampled(rob_ready));
        end

    a_trap_valid: assert property (@(posedge clk) disable iff (!arst_n)
        {trap.valid, rob_flush} == {2{trap_exp.valid}})
        else begin
            trap_errs++;
            $display("FAIL trap_valid_flush: expected %b actual %b",
                     $sampled({2{trap_exp.valid}}), $sampled({trap.valid, rob_flush}));
        end

    a_trap_fields: assert property (@(posedge clk) disable iff (!arst_n)
        trap_exp.valid |-> trap == trap_exp)
        else begin
            trap_errs++;
            $display("FAIL trap_fields: expected %h actual %h", $sampled(trap_exp),
                     $sampled(trap));
        end

    a_int_read: assert property (@(posedge clk) disable iff (!arst_n) int_rs_data == int_exp)
        else begin
            int_errs++;
            $display("FAIL int_read x%0d: expected %h actual %h", $sampled(int_rs_idx),
                     $sampled(int_exp), $sampled(int_rs_data));
        end

    a_fp_read: assert property (@(posedge clk) disable iff (!arst_n) fp_rs_data == fp_exp)
        else begin
            fp_errs++;
            $display("FAIL fp_read f%0d: expected %h actual %h", $sampled(fp_rs_idx),
                     $sampled(fp_exp), $sampled(fp_rs_data));
        end

    // Watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        int          sel;
        int          delay;
        int          start_pops;
        int          waited;
        logic [4:0]  prev_rd;
        rng_state    = 32'he1ed18fd;
        cycle_count  = 0;
        ready_errs   = 0;
        trap_errs    = 0;
        int_errs     = 0;
        fp_errs      = 0;
        rob_valid    = 1'b0;
        rob_head     = '0;
        rob_head_idx = '0;
        sb           = 1'b0;
        int_rs_idx   = '0;
        fp_rs_idx    = '0;
        kind         = '0;
        prev_rd      = '0;
        @(posedge arst_n);
        @(negedge clk);
        // Every register reads zero after reset
        for (int i = 0; i < 32; i++) begin
            int_rs_idx = i[4:0];
            fp_rs_idx  = 5'(31 - i);
            @(negedge clk);
        end
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            r  = lcg_next();
            r2 = lcg_next();
            // Occasional idle cycle with valid low
            if (r[31:29] == 3'd0) begin
                rob_valid = 1'b0;
                @(negedge clk);
            end
            sel   = int'(r[27:24]);
            kind  = kind_of(sel);
            delay = int'(r[19:18]) % 3;
            rob_head.instruction   = {r2[31:7], op_table[sel]};
            rob_head.rd_idx        = r2[20:16];
            rob_head.value         = {lcg_next(), lcg_next()};
            rob_head.pc            = {32'h0, lcg_next() & 32'hffff_fffc};
            rob_head.except_raised = (r[23:21] == 3'd0);
            rob_head.except_code   = r[15:12];
            // Unknown opcode only together with an exception
            if (rob_head.except_raised && r[20]) begin
                rob_head.instruction[6:0] = 7'h7f;
                kind = '0;
            end
            rob_head_idx = n[3:0];
            sb           = kind.store ? (delay == 0) : r[17];
            // Read ports watch the previously popped destination
            int_rs_idx   = prev_rd;
            fp_rs_idx    = prev_rd;
            rob_valid    = 1'b1;
            start_pops   = pop_count;
            waited       = 0;
            while (pop_count == start_pops) begin
                @(negedge clk);
                waited++;
                if (kind.store && waited >= delay) begin
                    sb = 1'b1;
                end
            end
            prev_rd = rob_head.rd_idx;
        end
        rob_valid  = 1'b0;
        int_rs_idx = prev_rd;
        fp_rs_idx  = prev_rd;
        repeat (3) @(negedge clk);
        report_counts();
        if (ready_errs + trap_errs + int_errs + fp_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
design/commit_pkg.sv
design/commit_decoder.sv
design/except_handler.sv
design/commit_logic.sv
design/reg_file.sv
design/commit_stage.sv
verif/tb_clock_gen.sv
verif/commit_stage_tb.sv
